// ==== hw/tetris_pkg.sv ====
package tetris_pkg;

	localparam int BOARD_ROWS = 24;
	localparam int BOARD_COLS = 24;

	// visible pixels per raster line
	localparam int H_RES = 640;

	typedef logic [3:0] shape_t;

	// row 0 is the top of the board
	typedef struct packed {
		logic       valid;
		logic [4:0] row;
		logic [4:0] col;
	} cell_t;

	typedef cell_t [3:0] footprint_t;

	typedef struct packed {
		logic [17:0] rsvd;
		shape_t      shape;
		logic [4:0]  row;
		logic [4:0]  col;
	} piece_cmd_t;

	typedef struct packed {
		logic [30:0] rsvd;
		logic        start_over;
	} ctrl_t;

	// same write word, command at address 0 and control at address 1
	typedef union packed {
		piece_cmd_t cmd;
		ctrl_t      ctrl;
	} wb_word_u;

	typedef struct packed {
		footprint_t foot;
		logic       stop;
		logic       hit;
	} probe_t;

	typedef struct packed {
		logic [21:0] rsvd;
		logic [7:0]  score;
		logic        hit;
		logic        stop;
	} status_t;

	typedef logic [BOARD_ROWS-1:0][BOARD_COLS-1:0] board_t;

endpackage

// ==== hw/wb_piece_port.sv ====
`timescale 1ns/1ns

module wb_piece_port import tetris_pkg::*; (
	input  logic        ADDR,
	input  logic        rst_n,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic        adr,
	input  logic [31:0] dat_w,
	input  logic        done,
	input  status_t     status,
	output logic        ack,
	output logic [31:0] dat_r,
	output logic        cmd_valid,
	output piece_cmd_t  cmd,
	output logic        start_over
);

	wb_word_u word;
	logic     busy;
	logic     req;
	logic     quick;

	assign word = dat_w;

	// a transfer that has not been taken yet
	assign req = cyc && stb && !busy && !ack;

	assign cmd_valid = req && we && !adr;
	assign cmd = word.cmd;

	// reads and control writes answer in one cycle
	assign quick = req && (!we || adr);
	assign start_over = quick && we && word.ctrl.start_over;

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			busy <= 1'b0;
			ack <= 1'b0;
		end else begin
			ack <= quick || (busy && done);
			if (cmd_valid)
				busy <= 1'b1;
			else if (done)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge ADDR) begin
		if (quick || done)
			dat_r <= status;
	end

	// host keeps the strobe up until it sees the answer
	a_ack_in_transfer: assert property (@(posedge ADDR) disable iff (!rst_n)
		ack |-> cyc && stb);

endmodule

// ==== hw/piece_footprint.sv ====
`timescale 1ns/1ns

module piece_footprint import tetris_pkg::*; (
	input  logic       ADDR,
	input  logic       rst_n,
	input  logic       cmd_valid,
	input  piece_cmd_t cmd,
	output logic       foot_valid,
	output footprint_t foot
);

	// 3-bit two's complement offsets
	localparam logic [2:0] P0 = 3'd0;
	localparam logic [2:0] P1 = 3'd1;
	localparam logic [2:0] P2 = 3'd2;
	localparam logic [2:0] P3 = 3'd3;
	localparam logic [2:0] M1 = 3'b111;
	localparam logic [2:0] M2 = 3'b110;

	logic [23:0]       ofs;
	logic signed [2:0] dr [4];
	logic signed [2:0] dc [4];
	logic signed [6:0] r_sum [4];
	logic signed [6:0] c_sum [4];
	footprint_t        cells;

	// row, col pairs, cell 0 in the top bits
	always_comb begin
		case (cmd.shape)
			4'd0: ofs = {P0, P0, P0, P1, P1, P0, P1, P1};
			4'd1: ofs = {P0, P0, P0, P1, P0, P2, P0, P3};
			4'd2: ofs = {P0, P0, P1, P0, P2, P0, P3, P0};
			4'd3: ofs = {P0, P0, P1, M1, P1, P0, P1, P1};
			4'd4: ofs = {P0, P0, P1, P0, P1, P1, P2, P0};
			4'd5: ofs = {P0, P0, P0, P1, P0, P2, P1, P1};
			4'd6: ofs = {P0, P0, P1, M1, P1, P0, P2, P0};
			4'd7: ofs = {P0, P0, P1, P0, P2, P0, P2, P1};
			4'd8: ofs = {P0, P0, P0, P1, P0, P2, P1, P0};
			4'd9: ofs = {P0, P0, P0, P1, P1, P1, P2, P1};
			4'd10: ofs = {P0, P0, P1, M2, P1, M1, P1, P0};
			4'd11: ofs = {P0, P0, P1, P0, P1, P1, P2, P1};
			4'd12: ofs = {P0, P0, P0, P1, P1, M1, P1, P0};
			4'd13: ofs = {P0, P0, P1, M1, P1, P0, P2, M1};
			default: ofs = {P0, P0, P0, P1, P1, P1, P1, P2};
		endcase
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			dr[i] = ofs[23-6*i -: 3];
			dc[i] = ofs[20-6*i -: 3];
			r_sum[i] = $signed({2'b00, cmd.row}) + dr[i];
			c_sum[i] = $signed({2'b00, cmd.col}) + dc[i];
			cells[i].valid = r_sum[i] >= 0 && r_sum[i] < BOARD_ROWS
				&& c_sum[i] >= 0 && c_sum[i] < BOARD_COLS;
			cells[i].row = r_sum[i][4:0];
			cells[i].col = c_sum[i][4:0];
		end
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n)
			foot_valid <= 1'b0;
		else
			foot_valid <= cmd_valid;
	end

	always_ff @(posedge ADDR) begin
		if (cmd_valid)
			foot <= cells;
	end

	// host only sends pieces that fit on the board
	a_cells_on_board: assert property (@(posedge ADDR) disable iff (!rst_n)
		cmd_valid |=> foot[0].valid && foot[1].valid
			&& foot[2].valid && foot[3].valid);

endmodule

// ==== hw/board_probe.sv ====
`timescale 1ns/1ns

module board_probe import tetris_pkg::*; (
	input  logic       ADDR,
	input  logic       rst_n,
	input  logic       foot_valid,
	input  footprint_t foot,
	input  board_t     board,
	output logic       probe_valid,
	output probe_t     probe
);

	localparam logic [4:0] LAST_ROW = 5'(BOARD_ROWS - 1);
	localparam logic [4:0] LAST_COL = 5'(BOARD_COLS - 1);

	logic stop_c;
	logic hit_c;

	always_comb begin
		stop_c = 1'b0;
		hit_c = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (foot[i].valid) begin
				// floor or something right below
				if (foot[i].row == LAST_ROW)
					stop_c = 1'b1;
				else if (board[foot[i].row + 5'd1][foot[i].col])
					stop_c = 1'b1;
				// walls, then side neighbors
				if (foot[i].col == 5'd0 || foot[i].col == LAST_COL)
					hit_c = 1'b1;
				else if (board[foot[i].row][foot[i].col - 5'd1]
					|| board[foot[i].row][foot[i].col + 5'd1])
					hit_c = 1'b1;
			end
		end
	end

	always_ff @(posedge ADDR) begin
		if (!rst_n)
			probe_valid <= 1'b0;
		else
			probe_valid <= foot_valid;
	end

	always_ff @(posedge ADDR) begin
		if (foot_valid) begin
			probe.foot <= foot;
			probe.stop <= stop_c;
			probe.hit <= hit_c;
		end
	end

endmodule

// ==== hw/playfield.sv ====
`timescale 1ns/1ns

module playfield import tetris_pkg::*; (
	input  logic    ADDR,
	input  logic    rst_n,
	input  logic    probe_valid,
	input  probe_t  probe,
	input  logic    start_over,
	output board_t  board,
	output board_t  view,
	output status_t status,
	output logic    done
);

	footprint_t            active;
	logic [7:0]            score;
	logic                  stop_q;
	logic                  hit_q;
	logic                  clearing;
	logic [BOARD_ROWS-1:0] rows_full;
	logic [4:0]            low_row;
	board_t                shifted;

	function automatic board_t piece_mask(footprint_t cells);
		board_t m;
		m = '0;
		for (int i = 0; i < 4; i++) begin
			if (cells[i].valid)
				m[cells[i].row][cells[i].col] = 1'b1;
		end
		return m;
	endfunction

	// last hit wins, so this finds the lowest full row
	always_comb begin
		low_row = '0;
		for (int r = 0; r < BOARD_ROWS; r++) begin
			rows_full[r] = &board[r];
			if (rows_full[r])
				low_row = 5'(r);
		end
	end

	// rows above the cleared one drop by one
	always_comb begin
		for (int r = 0; r < BOARD_ROWS; r++) begin
			if (5'(r) > low_row)
				shifted[r] = board[r];
			else if (r == 0)
				shifted[r] = '0;
			else
				shifted[r] = board[r-1];
		end
	end

	assign done = clearing && !(|rows_full);
	assign view = board | piece_mask(active);
	assign status = '{rsvd: '0, score: score, hit: hit_q, stop: stop_q};

	always_ff @(posedge ADDR) begin
		if (!rst_n || start_over) begin
			board <= '0;
			active <= '0;
			score <= '0;
			stop_q <= 1'b0;
			hit_q <= 1'b0;
			clearing <= 1'b0;
		end else if (probe_valid) begin
			stop_q <= probe.stop;
			hit_q <= probe.hit;
			clearing <= 1'b1;
			if (probe.stop) begin
				board <= board | piece_mask(probe.foot);
				active <= '0;
			end else begin
				active <= probe.foot;
			end
		end else if (clearing) begin
			// one row per cycle
			if (|rows_full) begin
				board <= shifted;
				score <= score + 8'd1;
			end else begin
				clearing <= 1'b0;
			end
		end
	end

	// a full row never outlives the clear sequence
	a_no_full_row_idle: assert property (@(posedge ADDR) disable iff (!rst_n)
		!clearing |-> rows_full == '0);

endmodule

// ==== hw/pixel_select.sv ====
`timescale 1ns/1ns

module pixel_select import tetris_pkg::*; #(
	parameter int CELL_PX = 20
) (
	input  logic        ADDR,
	input  logic        rst_n,
	input  logic        pix_valid,
	input  logic [18:0] pix_addr,
	input  board_t      view,
	output logic        sel_valid,
	output logic        sel
);

	localparam int XW = $clog2(H_RES);
	localparam int YW = $clog2((2 ** 19) / H_RES + 1);
	localparam int RW = $clog2(BOARD_ROWS);
	localparam int CW = $clog2(BOARD_COLS);
	// divider band right of the board
	localparam int BAND_LO = BOARD_COLS * CELL_PX;
	localparam int BAND_HI = (BOARD_COLS + 1) * CELL_PX;

	logic          v1;
	logic [XW-1:0] x1;
	logic [YW-1:0] row1;
	logic [XW-1:0] col1;
	logic          on_board;

	always_ff @(posedge ADDR) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			sel_valid <= 1'b0;
		end else begin
			v1 <= pix_valid;
			sel_valid <= v1;
		end
	end

	// stage one, address to x and cell
	always_ff @(posedge ADDR) begin
		x1 <= XW'(pix_addr % H_RES);
		row1 <= YW'(pix_addr / H_RES / CELL_PX);
		col1 <= XW'(pix_addr % H_RES / CELL_PX);
	end

	assign on_board = row1 < BOARD_ROWS && col1 < BOARD_COLS;

	always_ff @(posedge ADDR) begin
		sel <= (on_board && view[row1[RW-1:0]][col1[CW-1:0]])
			|| (x1 > BAND_LO && x1 < BAND_HI);
	end

endmodule

// ==== hw/tetris_core.sv ====
`timescale 1ns/1ns

module tetris_core import tetris_pkg::*; #(
	parameter int CELL_PX = 20
) (
	input  logic        ADDR,
	input  logic        rst_n,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic        adr,
	input  logic [31:0] dat_w,
	input  logic        pix_valid,
	input  logic [18:0] pix_addr,
	output logic        ack,
	output logic [31:0] dat_r,
	output logic        sel_valid,
	output logic        sel
);

	piece_cmd_t cmd;
	logic       cmd_valid;
	logic       start_over;
	footprint_t foot;
	logic       foot_valid;
	probe_t     probe;
	logic       probe_valid;
	board_t     board;
	board_t     view;
	status_t    status;
	logic       done;

	wb_piece_port wb_piece_port_i (
		.ADDR(ADDR), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .done(done), .status(status), .ack(ack), .dat_r(dat_r),
		.cmd_valid(cmd_valid), .cmd(cmd), .start_over(start_over)
	);

	piece_footprint piece_footprint_i (
		.ADDR(ADDR), .rst_n(rst_n), .cmd_valid(cmd_valid), .cmd(cmd),
		.foot_valid(foot_valid), .foot(foot)
	);

	board_probe board_probe_i (
		.ADDR(ADDR), .rst_n(rst_n), .foot_valid(foot_valid), .foot(foot),
		.board(board), .probe_valid(probe_valid), .probe(probe)
	);

	playfield playfield_i (
		.ADDR(ADDR), .rst_n(rst_n), .probe_valid(probe_valid), .probe(probe),
		.start_over(start_over), .board(board), .view(view), .status(status),
		.done(done)
	);

	pixel_select #(.CELL_PX(CELL_PX)) pixel_select_i (
		.ADDR(ADDR), .rst_n(rst_n), .pix_valid(pix_valid), .pix_addr(pix_addr),
		.view(view), .sel_valid(sel_valid), .sel(sel)
	);

endmodule

// ==== verif/tetris_model.svh ====
`ifndef TETRIS_MODEL_SVH
`define TETRIS_MODEL_SVH

// shape offsets, row then column, one line per shape
int shape_dr [16][4] = '{
	'{0, 0, 1, 1}, '{0, 0, 0, 0}, '{0, 1, 2, 3}, '{0, 1, 1, 1},
	'{0, 1, 1, 2}, '{0, 0, 0, 1}, '{0, 1, 1, 2}, '{0, 1, 2, 2},
	'{0, 0, 0, 1}, '{0, 0, 1, 2}, '{0, 1, 1, 1}, '{0, 1, 1, 2},
	'{0, 0, 1, 1}, '{0, 1, 1, 2}, '{0, 0, 1, 1}, '{0, 0, 1, 1}
};
int shape_dc [16][4] = '{
	'{0, 1, 0, 1}, '{0, 1, 2, 3}, '{0, 0, 0, 0}, '{0, -1, 0, 1},
	'{0, 0, 1, 0}, '{0, 1, 2, 1}, '{0, -1, 0, 0}, '{0, 0, 0, 1},
	'{0, 1, 2, 0}, '{0, 1, 1, 1}, '{0, -2, -1, 0}, '{0, 0, 1, 1},
	'{0, 1, -1, 0}, '{0, -1, 0, -1}, '{0, 1, 1, 2}, '{0, 1, 1, 2}
};

bit m_board [BOARD_ROWS][BOARD_COLS];
bit m_active [BOARD_ROWS][BOARD_COLS];
int m_score;
bit m_stop;
bit m_hit;

function automatic bit piece_fits(int shape, int row, int col);
	int r;
	int c;
	for (int i = 0; i < 4; i++) begin
		r = row + shape_dr[shape][i];
		c = col + shape_dc[shape][i];
		if (r < 0 || r >= BOARD_ROWS || c < 0 || c >= BOARD_COLS)
			return 1'b0;
	end
	return 1'b1;
endfunction

// stop in bit 1, hit in bit 0
function automatic logic [1:0] model_probe(int shape, int row, int col);
	int r;
	int c;
	logic [1:0] res;
	res = 2'b00;
	for (int i = 0; i < 4; i++) begin
		r = row + shape_dr[shape][i];
		c = col + shape_dc[shape][i];
		if (r == BOARD_ROWS - 1)
			res[1] = 1'b1;
		else if (m_board[r+1][c])
			res[1] = 1'b1;
		if (c == 0 || c == BOARD_COLS - 1)
			res[0] = 1'b1;
		else if (m_board[r][c-1] || m_board[r][c+1])
			res[0] = 1'b1;
	end
	return res;
endfunction

// returns the number of removed rows
function automatic int model_command(int shape, int row, int col);
	int cleared;
	int low;
	bit full;
	{m_stop, m_hit} = model_probe(shape, row, col);
	foreach (m_active[r, c])
		m_active[r][c] = 1'b0;
	for (int i = 0; i < 4; i++) begin
		if (m_stop)
			m_board[row + shape_dr[shape][i]][col + shape_dc[shape][i]] = 1'b1;
		else
			m_active[row + shape_dr[shape][i]][col + shape_dc[shape][i]] = 1'b1;
	end
	cleared = 0;
	do begin
		low = -1;
		for (int r = 0; r < BOARD_ROWS; r++) begin
			full = 1'b1;
			for (int c = 0; c < BOARD_COLS; c++)
				full = full & m_board[r][c];
			if (full)
				low = r;
		end
		// drop everything above the lowest full row
		if (low >= 0) begin
			for (int r = low; r > 0; r--)
				m_board[r] = m_board[r-1];
			for (int c = 0; c < BOARD_COLS; c++)
				m_board[0][c] = 1'b0;
			cleared++;
			m_score = (m_score + 1) % 256;
		end
	end while (low >= 0);
	return cleared;
endfunction

function automatic void model_start_over();
	foreach (m_board[r, c]) begin
		m_board[r][c] = 1'b0;
		m_active[r][c] = 1'b0;
	end
	m_score = 0;
	m_stop = 1'b0;
	m_hit = 1'b0;
endfunction

function automatic logic [31:0] model_status();
	return {22'd0, 8'(m_score), m_hit, m_stop};
endfunction

function automatic bit model_pixel(int addr);
	int x;
	int row;
	int col;
	bit on;
	x = addr % H_RES;
	row = addr / H_RES / CELL_PX;
	col = x / CELL_PX;
	on = 1'b0;
	if (row < BOARD_ROWS && col < BOARD_COLS)
		on = m_board[row][col] | m_active[row][col];
	// divider band one cell wide
	return on || (x > BOARD_COLS * CELL_PX && x < (BOARD_COLS + 1) * CELL_PX);
endfunction

`endif

// ==== verif/tetris_tb.sv ====
`timescale 1ns/1ns

module tetris_tb import tetris_pkg::*; ();

	localparam int CELL_PX = 20;
	localparam int ACK_LIMIT = 64;

	logic        ADDR;
	logic        rst_n;
	logic        cyc;
	logic        stb;
	logic        we;
	logic        adr;
	logic [31:0] dat_w;
	logic        pix_valid;
	logic [18:0] pix_addr;
	logic        ack;
	logic [31:0] dat_r;
	logic        sel_valid;
	logic        sel;

	int seed = 98284;
	int pix_q[$];

	`include "tetris_model.svh"

	tetris_core #(.CELL_PX(CELL_PX)) tetris_core_i (
		.ADDR(ADDR), .rst_n(rst_n), .cyc(cyc), .stb(stb), .we(we), .adr(adr),
		.dat_w(dat_w), .pix_valid(pix_valid), .pix_addr(pix_addr), .ack(ack),
		.dat_r(dat_r), .sel_valid(sel_valid), .sel(sel)
	);

	always #2 ADDR = ~ADDR;

	task report_failure(input string line);
		$display("%s", line);
		$display("FAIL: see errors above");
		$fatal(1, "stopped at first error");
	endtask

	task check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
			report_failure($sformatf("Fail at %0t: %s is %0h, expected %0h",
				$time, name, got, exp));
	endtask

	function automatic int rand_below(int n);
		return ($random(seed) & 32'h7fff_ffff) % n;
	endfunction

	// one Wishbone classic transfer, n counts cycles until ack
	task bus_transfer(input logic w, input logic a, input logic [31:0] d,
		output logic [31:0] q, output int n);
		@(negedge ADDR);
		check_value("ack", 32'(ack), 32'd0);
		cyc = 1'b1;
		stb = 1'b1;
		we = w;
		adr = a;
		dat_w = d;
		n = 0;
		do begin
			@(negedge ADDR);
			n++;
			if (n > ACK_LIMIT)
				report_failure("the bus gave no ack within the time limit");
		end while (!ack);
		q = dat_r;
		// strobe stays up through the edge that samples ack
		@(negedge ADDR);
		check_value("ack", 32'(ack), 32'd0);
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
	endtask

	task read_status(input logic a);
		logic [31:0] q;
		int n;
		bus_transfer(1'b0, a, 32'd0, q, n);
		check_value("read ack latency", n, 1);
		check_value("dat_r", q, model_status());
	endtask

	task start_over_write();
		logic [31:0] q;
		int n;
		bus_transfer(1'b1, 1'b1, {31'(rand_below(32'h4000_0000)), 1'b1}, q, n);
		check_value("control ack latency", n, 1);
		model_start_over();
	endtask

	task send_piece(input int shape, input int row, input int col);
		logic [31:0] q;
		int n;
		int cleared;
		cleared = model_command(shape, row, col);
		bus_transfer(1'b1, 1'b0, {18'd0, 4'(shape), 5'(row), 5'(col)}, q, n);
		check_value("command ack latency", n, 4 + cleared);
		read_status(1'b0);
	endtask

	task random_piece(input bit no_stop);
		int shape;
		int row;
		int col;
		int tries;
		bit ok;
		logic [1:0] pr;
		tries = 0;
		do begin
			shape = rand_below(16);
			row = rand_below(BOARD_ROWS);
			col = rand_below(BOARD_COLS);
			ok = piece_fits(shape, row, col);
			if (ok && no_stop) begin
				pr = model_probe(shape, row, col);
				ok = !pr[1];
			end
			tries++;
			if (tries > 10000)
				report_failure("no piece found that stays in the air");
		end while (!ok);
		send_piece(shape, row, col);
	endtask

	// one pixel inside every board cell
	task queue_cells();
		pix_q.delete();
		for (int r = 0; r < BOARD_ROWS; r++)
			for (int c = 0; c < BOARD_COLS; c++)
				pix_q.push_back((r * CELL_PX + rand_below(CELL_PX)) * H_RES
					+ c * CELL_PX + rand_below(CELL_PX));
	endtask

	task queue_random(input int count);
		pix_q.delete();
		for (int i = 0; i < count; i++) begin
			if (rand_below(8) == 0)
				pix_q.push_back(rand_below(1 << 19));
			else
				pix_q.push_back(rand_below(500) * H_RES + rand_below(H_RES));
		end
	endtask

	// back to back, result due two cycles after each pixel
	task stream_pixels();
		int n;
		n = pix_q.size();
		for (int k = 0; k < n + 2; k++) begin
			@(negedge ADDR);
			if (k >= 2) begin
				check_value("sel_valid", 32'(sel_valid), 32'd1);
				check_value("sel", 32'(sel), 32'(model_pixel(pix_q[k-2])));
			end else begin
				check_value("sel_valid", 32'(sel_valid), 32'd0);
			end
			pix_valid = k < n;
			pix_addr = k < n ? 19'(pix_q[k]) : 19'd0;
		end
		@(negedge ADDR);
		check_value("sel_valid", 32'(sel_valid), 32'd0);
	endtask

	initial begin
		ADDR = 1'b0;
		rst_n = 1'b0;
		cyc = 1'b0;
		stb = 1'b0;
		we = 1'b0;
		adr = 1'b0;
		dat_w = 32'd0;
		pix_valid = 1'b0;
		pix_addr = 19'd0;
		model_start_over();
		repeat (16) @(negedge ADDR);
		rst_n = 1'b1;

		repeat (8) begin
			@(negedge ADDR);
			check_value("sel_valid", 32'(sel_valid), 32'd0);
			check_value("ack", 32'(ack), 32'd0);
		end
		read_status(1'b0);
		read_status(1'b1);

		repeat (300) random_piece(1'b0);
		read_status(1'b1);

		// fill the bottom row with flat pieces
		start_over_write();
		read_status(1'b0);
		for (int c = 0; c < BOARD_COLS; c += 4)
			send_piece(1, BOARD_ROWS - 1, c);
		repeat (100) random_piece(1'b0);
		queue_random(300);
		stream_pixels();

		start_over_write();
		read_status(1'b0);
		read_status(1'b1);
		queue_cells();
		stream_pixels();

		// leave one piece hanging for the view
		repeat (40) random_piece(1'b0);
		random_piece(1'b1);
		queue_random(500);
		stream_pixels();

		$display("PASS: all tests");
		$finish;
	end

endmodule

// ==== tetris.f ====
+incdir+verif
hw/tetris_pkg.sv
hw/wb_piece_port.sv
hw/piece_footprint.sv
hw/board_probe.sv
hw/playfield.sv
hw/pixel_select.sv
hw/tetris_core.sv
verif/tetris_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -f tetris.f --top-module tetris_tb -o tetris_sim \
	&& ./obj_dir/tetris_sim \
	|| exit 1
